/* Bender.yml */
package:
  name: pipeline

sources:
  - files:
      - hdl/pipe_pkg.sv
      - hdl/pipe_reg.sv
      - hdl/reg_access_stage.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/pipeline_top.sv
  - target: test
    files:
      - verif/pipeline_tb.sv

/* hdl/execute_stage.sv */
module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              issue_valid,
   output logic              issue_ready,
   input  pipe_pkg::issue_t  issue_data,
   output logic              res_valid,
   input  logic              res_ready,
   output pipe_pkg::result_t res_data
);

   pipe_pkg::data_t   alu_out;
   logic [4:0]        shamt;
   pipe_pkg::result_t res_in;

   assign shamt = issue_data.op_b[4:0];

   always_comb begin
      case (issue_data.alu_op)
         pipe_pkg::alu_add: alu_out = issue_data.op_a + issue_data.op_b;
         pipe_pkg::alu_sub: alu_out = issue_data.op_a - issue_data.op_b;
         pipe_pkg::alu_and: alu_out = issue_data.op_a & issue_data.op_b;
         pipe_pkg::alu_or:  alu_out = issue_data.op_a | issue_data.op_b;
         pipe_pkg::alu_xor: alu_out = issue_data.op_a ^ issue_data.op_b;
         pipe_pkg::alu_shl: alu_out = issue_data.op_a << shamt;
         pipe_pkg::alu_shr: alu_out = issue_data.op_a >> shamt;
         pipe_pkg::alu_mov: alu_out = issue_data.op_b;
         default:           alu_out = '0;
      endcase
   end

   // Stores carry the computed address in result
   always_comb begin
      res_in.dest       = issue_data.dest;
      res_in.result     = alu_out;
      res_in.store_data = issue_data.store_data;
      res_in.to_mem     = issue_data.to_mem;
   end

   pipe_reg #(
      .payload_t (pipe_pkg::result_t)
   ) result_reg_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (issue_valid),
      .in_data   (res_in),
      .in_ready  (issue_ready),
      .out_valid (res_valid),
      .out_data  (res_data),
      .out_ready (res_ready)
   );

endmodule

/* hdl/pipe_pkg.sv */
package pipe_pkg;

   localparam int data_w    = 32;   // Datapath and wmem address width
   localparam int reg_idx_w = 3;

   typedef logic [data_w-1:0]    data_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   // Shift amounts come from op_b[4:0]
   typedef enum logic [2:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_xor = 3'd4,
      alu_shl = 3'd5,
      alu_shr = 3'd6,   // Logical, zero fill
      alu_mov = 3'd7    // Passes op_b
   } alu_op_e;

   // Register access to execute
   typedef struct packed {
      alu_op_e  alu_op;
      reg_idx_t dest;
      data_t    op_a;
      data_t    op_b;        // Immediate or src_b value
      data_t    store_data;  // Always the src_b value
      logic     to_mem;
   } issue_t;

   // Execute to writeback
   typedef struct packed {
      reg_idx_t dest;
      data_t    result;      // Store address when to_mem is set
      data_t    store_data;
      logic     to_mem;
   } result_t;

endpackage

/* hdl/pipe_reg.sv */
module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   // Empty slot, or the held entry leaves this cycle
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;   // Drops to zero when drained with nothing behind
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

/* hdl/pipeline_top.sv */
module pipeline_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               op_valid,
   output logic               op_ready,
   input  pipe_pkg::alu_op_e  op_alu,
   input  pipe_pkg::reg_idx_t op_dest,
   input  pipe_pkg::reg_idx_t op_src_a,
   input  pipe_pkg::reg_idx_t op_src_b,
   input  pipe_pkg::data_t    op_imm,
   input  logic               op_use_imm,
   input  logic               op_to_mem,
   output logic               retire_valid,
   output pipe_pkg::reg_idx_t retire_dest,
   output pipe_pkg::data_t    retire_data,
   output logic               wmem_valid,
   input  logic               wmem_ready,
   output pipe_pkg::data_t    wmem_address,
   output pipe_pkg::data_t    wmem_data
);

   logic               issue_valid;
   logic               issue_ready;
   pipe_pkg::issue_t   issue_data;
   logic               res_valid;
   logic               res_ready;
   pipe_pkg::result_t  res_data;
   logic               wr_en;       // Writeback to register file
   pipe_pkg::reg_idx_t wr_dest;
   pipe_pkg::data_t    wr_data;

   reg_access_stage reg_access_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .op_valid    (op_valid),
      .op_ready    (op_ready),
      .op_alu      (op_alu),
      .op_dest     (op_dest),
      .op_src_a    (op_src_a),
      .op_src_b    (op_src_b),
      .op_imm      (op_imm),
      .op_use_imm  (op_use_imm),
      .op_to_mem   (op_to_mem),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue_data  (issue_data),
      .wr_en       (wr_en),
      .wr_dest     (wr_dest),
      .wr_data     (wr_data)
   );

   execute_stage execute_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue_data  (issue_data),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_data    (res_data)
   );

   writeback_stage writeback_inst (
      .res_valid    (res_valid),
      .res_ready    (res_ready),
      .res_data     (res_data),
      .wr_en        (wr_en),
      .wr_dest      (wr_dest),
      .wr_data      (wr_data),
      .retire_valid (retire_valid),
      .retire_dest  (retire_dest),
      .retire_data  (retire_data),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_data    (wmem_data)
   );

endmodule

/* hdl/reg_access_stage.sv */
module reg_access_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                op_valid,
   output logic                op_ready,
   input  pipe_pkg::alu_op_e   op_alu,
   input  pipe_pkg::reg_idx_t  op_dest,
   input  pipe_pkg::reg_idx_t  op_src_a,
   input  pipe_pkg::reg_idx_t  op_src_b,
   input  pipe_pkg::data_t     op_imm,
   input  logic                op_use_imm,
   input  logic                op_to_mem,
   output logic                issue_valid,
   input  logic                issue_ready,
   output pipe_pkg::issue_t    issue_data,
   input  logic                wr_en,
   input  pipe_pkg::reg_idx_t  wr_dest,
   input  pipe_pkg::data_t     wr_data
);

   localparam int num_regs = 2 ** pipe_pkg::reg_idx_w;

   pipe_pkg::data_t   regs [num_regs];
   logic [num_regs-1:0] pending;   // Scoreboard, one bit per register
   logic              run;
   logic              use_b;
   logic              writes_reg;
   logic              hazard;
   logic              pipe_in_ready;
   logic              accept;
   pipe_pkg::issue_t  issue_in;

   assign use_b      = !op_use_imm || op_to_mem;   // Stores always read src_b as data
   assign writes_reg = !op_to_mem;

   // Waiting on dest as well keeps a single pending bit exact for repeated writes
   assign hazard = pending[op_src_a]
                || (use_b && pending[op_src_b])
                || (writes_reg && pending[op_dest]);

   assign op_ready = run && pipe_in_ready && !hazard;
   assign accept   = op_valid && op_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;   // Hold off the input port for the first cycle out of reset
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wr_en) begin
         regs[wr_dest] <= wr_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= '0;
      end else begin
         if (wr_en) begin
            pending[wr_dest] <= 1'b0;
         end
         if (accept && writes_reg) begin
            pending[op_dest] <= 1'b1;
         end
      end
   end

   always_comb begin
      issue_in.alu_op     = op_alu;
      issue_in.dest       = op_dest;
      issue_in.op_a       = regs[op_src_a];
      issue_in.op_b       = op_use_imm ? op_imm : regs[op_src_b];
      issue_in.store_data = regs[op_src_b];
      issue_in.to_mem     = op_to_mem;
   end

   pipe_reg #(
      .payload_t (pipe_pkg::issue_t)
   ) issue_reg_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (op_valid && run && !hazard),
      .in_data   (issue_in),
      .in_ready  (pipe_in_ready),
      .out_valid (issue_valid),
      .out_data  (issue_data),
      .out_ready (issue_ready)
   );

endmodule

/* hdl/writeback_stage.sv */
module writeback_stage (
   input  logic               res_valid,
   output logic               res_ready,
   input  pipe_pkg::result_t  res_data,
   output logic               wr_en,
   output pipe_pkg::reg_idx_t wr_dest,
   output pipe_pkg::data_t    wr_data,
   output logic               retire_valid,
   output pipe_pkg::reg_idx_t retire_dest,
   output pipe_pkg::data_t    retire_data,
   output logic               wmem_valid,
   input  logic               wmem_ready,
   output pipe_pkg::data_t    wmem_address,
   output pipe_pkg::data_t    wmem_data
);

   logic is_store;

   assign is_store = res_data.to_mem;

   // Register ops always drain, stores wait for the memory side
   assign res_ready = is_store ? wmem_ready : 1'b1;

   // Register write back into the register access stage
   assign wr_en   = res_valid && !is_store;
   assign wr_dest = res_data.dest;
   assign wr_data = res_data.result;

   assign retire_valid = wr_en;   // One cycle per op, since res_ready is high
   assign retire_dest  = res_data.dest;
   assign retire_data  = res_data.result;

   // Held stable by the result register while wmem_ready is low
   assign wmem_valid   = res_valid && is_store;
   assign wmem_address = res_data.result;
   assign wmem_data    = res_data.store_data;

endmodule

/* verif/pipeline_tb.sv */
module pipeline_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_rows    = 26;
   localparam int drive_delay = 1;   // ns after the rising edge
   localparam int drain_limit = 64;  // Cycles allowed for the last ops to leave

   typedef struct {
      pipe_pkg::alu_op_e  alu;
      pipe_pkg::reg_idx_t dest;
      pipe_pkg::reg_idx_t src_a;
      pipe_pkg::reg_idx_t src_b;
      pipe_pkg::data_t    imm;
      logic               use_imm;
      logic               to_mem;
   } op_row_t;

   typedef struct {
      pipe_pkg::reg_idx_t dest;
      pipe_pkg::data_t    data;
   } retire_exp_t;

   typedef struct {
      pipe_pkg::data_t address;
      pipe_pkg::data_t data;
   } store_exp_t;

   logic               clk = 1'b0;
   logic               rst_n;
   logic               op_valid;
   logic               op_ready;
   pipe_pkg::alu_op_e  op_alu;
   pipe_pkg::reg_idx_t op_dest;
   pipe_pkg::reg_idx_t op_src_a;
   pipe_pkg::reg_idx_t op_src_b;
   pipe_pkg::data_t    op_imm;
   logic               op_use_imm;
   logic               op_to_mem;
   logic               retire_valid;
   pipe_pkg::reg_idx_t retire_dest;
   pipe_pkg::data_t    retire_data;
   logic               wmem_valid;
   logic               wmem_ready;
   pipe_pkg::data_t    wmem_address;
   pipe_pkg::data_t    wmem_data;

   op_row_t         rows [num_rows];
   pipe_pkg::data_t model_regs [8];
   retire_exp_t     retire_q [$];
   store_exp_t      store_q [$];
   retire_exp_t     exp_ret;
   store_exp_t      exp_st;
   logic            random_ready = 1'b0;
   logic            wmem_held = 1'b0;
   pipe_pkg::data_t held_address;
   pipe_pkg::data_t held_data;
   int              value_errors = 0;
   int              other_errors = 0;
   int              drain_cycles;

   pipeline_top pipeline_top_inst (.*);

   always #4 clk = ~clk;

   // Back-pressure on the store port
   initial begin
      logic next_ready;
      void'($urandom(2281));
      forever begin
         @(posedge clk);
         next_ready = random_ready ? (($urandom & 1) == 1) : 1'b1;
         #drive_delay;
         wmem_ready = next_ready;
      end
   end

   function automatic pipe_pkg::data_t alu_ref(input pipe_pkg::alu_op_e op,
                                               input pipe_pkg::data_t a,
                                               input pipe_pkg::data_t b);
      case (op)
         pipe_pkg::alu_add: return a + b;
         pipe_pkg::alu_sub: return a - b;
         pipe_pkg::alu_and: return a & b;
         pipe_pkg::alu_or:  return a | b;
         pipe_pkg::alu_xor: return a ^ b;
         pipe_pkg::alu_shl: return a << b[4:0];
         pipe_pkg::alu_shr: return a >> b[4:0];
         default:           return b;   // mov
      endcase
   endfunction

   task automatic set_row(input int idx, input pipe_pkg::alu_op_e alu, input int dest,
                          input int src_a, input int src_b, input pipe_pkg::data_t imm,
                          input logic use_imm, input logic to_mem);
      rows[idx] = '{alu, dest[2:0], src_a[2:0], src_b[2:0], imm, use_imm, to_mem};
   endtask

   // In-order reference, fills the expected queues
   task automatic build_expected();
      pipe_pkg::data_t a;
      pipe_pkg::data_t b;
      pipe_pkg::data_t res;
      foreach (model_regs[i]) model_regs[i] = '0;
      for (int i = 0; i < num_rows; i++) begin
         a   = model_regs[rows[i].src_a];
         b   = rows[i].use_imm ? rows[i].imm : model_regs[rows[i].src_b];
         res = alu_ref(rows[i].alu, a, b);
         if (rows[i].to_mem) begin
            store_q.push_back('{res, model_regs[rows[i].src_b]});
         end else begin
            model_regs[rows[i].dest] = res;
            retire_q.push_back('{rows[i].dest, res});
         end
      end
   endtask

   task automatic send_op(input int idx);
      op_valid   = 1'b1;
      op_alu     = rows[idx].alu;
      op_dest    = rows[idx].dest;
      op_src_a   = rows[idx].src_a;
      op_src_b   = rows[idx].src_b;
      op_imm     = rows[idx].imm;
      op_use_imm = rows[idx].use_imm;
      op_to_mem  = rows[idx].to_mem;
      @(negedge clk);
      while (!op_ready) @(negedge clk);
      @(posedge clk);   // Accepted here
      #drive_delay;
      op_valid = 1'b0;
   endtask

   // Retire monitor
   always @(negedge clk) begin
      if (rst_n && retire_valid) begin
         if (retire_q.size() == 0) begin
            other_errors++;
            $display("Retire report at %0t with no register operation outstanding", $time);
         end else begin
            exp_ret = retire_q.pop_front();
            assert (retire_dest == exp_ret.dest) else begin
               value_errors++;
               $display("CHECK FAILED t=%0t retire_dest expected %0d got %0d",
                        $time, exp_ret.dest, retire_dest);
            end
            assert (retire_data == exp_ret.data) else begin
               value_errors++;
               $display("CHECK FAILED t=%0t retire_data expected %h got %h",
                        $time, exp_ret.data, retire_data);
            end
         end
      end
   end

   // Store monitor, including hold under back-pressure
   always @(negedge clk) begin
      if (rst_n && wmem_held) begin
         assert (wmem_valid && wmem_address == held_address && wmem_data == held_data) else begin
            other_errors++;
            $display("Store at %0t changed or dropped while wmem_ready was low", $time);
         end
      end
      if (rst_n && wmem_valid && wmem_ready) begin
         if (store_q.size() == 0) begin
            other_errors++;
            $display("Store at %0t with no store operation outstanding", $time);
         end else begin
            exp_st = store_q.pop_front();
            assert (wmem_address == exp_st.address) else begin
               value_errors++;
               $display("CHECK FAILED t=%0t wmem_address expected %h got %h",
                        $time, exp_st.address, wmem_address);
            end
            assert (wmem_data == exp_st.data) else begin
               value_errors++;
               $display("CHECK FAILED t=%0t wmem_data expected %h got %h",
                        $time, exp_st.data, wmem_data);
            end
         end
      end
      wmem_held    = rst_n && wmem_valid && !wmem_ready;
      held_address = wmem_address;
      held_data    = wmem_data;
   end

   initial begin
      #((num_rows * 20 + 16) * 8);
      $display("Timeout after %0t, the pipeline stopped making progress", $time);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      rst_n      = 1'b0;
      op_valid   = 1'b0;
      op_alu     = pipe_pkg::alu_add;
      op_dest    = '0;
      op_src_a   = '0;
      op_src_b   = '0;
      op_imm     = '0;
      op_use_imm = 1'b0;
      op_to_mem  = 1'b0;
      wmem_ready = 1'b1;

      //      idx  op                 dst sa sb imm           imm mem
      set_row(0,  pipe_pkg::alu_or,  7, 2, 3, 32'h0000_0000, 0, 0);   // Zero after reset
      set_row(1,  pipe_pkg::alu_or,  6, 4, 5, 32'h0000_0000, 0, 0);
      set_row(2,  pipe_pkg::alu_add, 1, 0, 0, 32'h0000_1234, 1, 0);
      set_row(3,  pipe_pkg::alu_mov, 2, 0, 0, 32'hdead_beef, 1, 0);
      set_row(4,  pipe_pkg::alu_sub, 3, 1, 0, 32'h0000_0034, 1, 0);
      set_row(5,  pipe_pkg::alu_and, 4, 2, 0, 32'h0000_ffff, 1, 0);
      set_row(6,  pipe_pkg::alu_or,  5, 4, 0, 32'h00f0_0000, 1, 0);   // Uses r4 right away
      set_row(7,  pipe_pkg::alu_xor, 6, 2, 0, 32'hffff_ffff, 1, 0);
      set_row(8,  pipe_pkg::alu_shl, 7, 1, 0, 32'h0000_0004, 1, 0);
      set_row(9,  pipe_pkg::alu_shr, 0, 2, 0, 32'h0000_0024, 1, 0);   // Only low 5 bits count
      set_row(10, pipe_pkg::alu_add, 1, 1, 1, 32'h0000_0000, 0, 0);
      set_row(11, pipe_pkg::alu_sub, 2, 1, 0, 32'h0000_0000, 0, 0);
      set_row(12, pipe_pkg::alu_mov, 3, 0, 7, 32'h0000_0000, 0, 0);
      set_row(13, pipe_pkg::alu_add, 0, 1, 2, 32'h0000_0100, 1, 1);   // Store r2 at r1+0x100
      set_row(14, pipe_pkg::alu_add, 0, 0, 7, 32'h0000_0004, 1, 1);
      set_row(15, pipe_pkg::alu_add, 7, 7, 0, 32'h0000_0001, 1, 0);
      set_row(16, pipe_pkg::alu_add, 7, 7, 7, 32'h0000_0000, 0, 0);
      set_row(17, pipe_pkg::alu_add, 0, 7, 3, 32'h0000_0000, 1, 1);
      set_row(18, pipe_pkg::alu_shl, 4, 5, 6, 32'h0000_0000, 0, 0);
      set_row(19, pipe_pkg::alu_shr, 5, 4, 0, 32'h0000_0003, 1, 0);
      set_row(20, pipe_pkg::alu_add, 0, 3, 5, 32'h0000_0008, 1, 1);
      set_row(21, pipe_pkg::alu_add, 0, 4, 0, 32'h0000_000c, 1, 1);
      set_row(22, pipe_pkg::alu_xor, 0, 0, 7, 32'h0000_0000, 0, 0);
      set_row(23, pipe_pkg::alu_mov, 6, 0, 0, 32'h55aa_55aa, 1, 0);
      set_row(24, pipe_pkg::alu_add, 0, 6, 0, 32'h0000_0000, 1, 1);
      set_row(25, pipe_pkg::alu_sub, 1, 0, 6, 32'h0000_0000, 0, 0);
      build_expected();

      repeat (16) @(posedge clk);
      assert (!retire_valid && !wmem_valid && !op_ready) else begin
         other_errors++;
         $display("Outputs were active while reset was asserted");
      end
      #drive_delay;
      rst_n = 1'b1;

      for (int i = 0; i < num_rows; i++) begin
         random_ready = (i >= 12 && i < 22);
         send_op(i);
      end
      random_ready = 1'b0;

      drain_cycles = 0;
      while ((retire_q.size() != 0 || store_q.size() != 0) && drain_cycles < drain_limit) begin
         @(negedge clk);
         drain_cycles++;
      end
      repeat (4) @(negedge clk);   // Catch any extra output
      assert (retire_q.size() == 0 && store_q.size() == 0) else begin
         other_errors++;
         $display("Expected retires or stores never appeared");
      end

      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
hdl/pipe_pkg.sv
hdl/pipe_reg.sv
hdl/reg_access_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/pipeline_top.sv
verif/pipeline_tb.sv
